/* Bender.yml */
package:
  name: vector_unit

sources:
  - source/vec_pkg.sv
  - source/coef_lfsr.sv
  - source/vec_ctrl.sv
  - source/elem_alu.sv
  - source/result_buffer.sv
  - source/vector_unit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_vector_unit.sv

/* sim.f */
+incdir+testbench
source/vec_pkg.sv
source/coef_lfsr.sv
source/vec_ctrl.sv
source/elem_alu.sv
source/result_buffer.sv
source/vector_unit.sv
testbench/tb_vector_unit.sv

/* source/coef_lfsr.sv */
////////////////////////////////////////
// Coefficient LFSR, 64 bit
// Steps once per accepted start
////////////////////////////////////////

`timescale 1ns/10ps

module coef_lfsr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance,
    output logic [vec_pkg::lfsr_w-1:0] lfsr_state
);

    import vec_pkg::*;

    logic feedback;

    // Taps at 63, 31 and 15
    assign feedback = lfsr_state[lfsr_w-1] ^ lfsr_state[31] ^ lfsr_state[15];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_state <= lfsr_seed;
        end else if (advance) begin
            lfsr_state <= {lfsr_state[lfsr_w-2:0], feedback};  // Shift left
        end
    end

    // All-zero is a lock-up state for this XOR feedback
    a_never_zero: assert property (
        @(posedge clk) disable iff (rst)
        lfsr_state != '0
    );

endmodule

/* source/elem_alu.sv */
////////////////////////////////////////
// Element ALU
// One byte pair in, one 16-bit result out
////////////////////////////////////////

`timescale 1ns/10ps

module elem_alu (
    input  logic [vec_pkg::vec_w-1:0]  vector_a,
    input  logic [vec_pkg::vec_w-1:0]  vector_b,
    input  logic [vec_pkg::idx_w-1:0]  elem_idx,
    input  vec_pkg::vec_op_e           vector_op,
    input  logic [vec_pkg::lfsr_w-1:0] lfsr_state,
    output logic [vec_pkg::res_w-1:0]  elem_result
);

    import vec_pkg::*;

    logic [elem_w-1:0] a;
    logic [elem_w-1:0] b;
    logic [elem_w-1:0] c;
    logic [elem_w-1:0] d;
    logic [elem_w-1:0] e;
    logic [elem_w-1:0] max_ab;
    logic [elem_w-1:0] abs_diff;
    logic [res_w-1:0]  product;

    // Element 0 sits in the low byte
    assign a = vector_a[elem_idx * elem_w +: elem_w];
    assign b = vector_b[elem_idx * elem_w +: elem_w];

    // Coefficient bytes from the low end of the LFSR
    assign c = lfsr_state[23:16];
    assign d = lfsr_state[15:8];
    assign e = lfsr_state[7:0];

    assign max_ab   = (a > b) ? a : b;
    assign abs_diff = (a > b) ? (a - b) : (b - a);
    assign product  = res_w'(a) * res_w'(b);  // 8x8 fits in 16 bits

    always_comb begin
        case (vector_op)
            op_add: begin
                elem_result = res_w'(a) + res_w'(b);
            end
            op_sub: begin
                elem_result = res_w'(a) - res_w'(b);  // Two's complement wrap
            end
            op_mul: begin
                elem_result = product;
            end
            op_mac: begin
                elem_result = product + res_w'(c);  // Modulo 2^16
            end
            op_logic: begin
                elem_result = {a & b, a | b};
            end
            op_xor: begin
                elem_result = {c, a ^ b};
            end
            op_max: begin
                elem_result = {e, max_ab};
            end
            op_sad: begin
                elem_result = res_w'(abs_diff) + res_w'(d);
            end
            default: begin
                elem_result = '0;
            end
        endcase
    end

endmodule

/* source/result_buffer.sv */
////////////////////////////////////////
// Result buffer, eight 16-bit slots
////////////////////////////////////////

`timescale 1ns/10ps

module result_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  logic [vec_pkg::idx_w-1:0]     elem_idx,
    input  logic [vec_pkg::res_w-1:0]     elem_result,
    output logic [vec_pkg::res_vec_w-1:0] vector_result
);

    import vec_pkg::*;

    // Only the addressed slot changes, the rest hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vector_result <= '0;
        end else if (wr_en) begin
            vector_result[elem_idx * res_w +: res_w] <= elem_result;
        end
    end

endmodule

/* source/vec_ctrl.sv */
////////////////////////////////////////
// Vector unit controller FSM
// Steps eight elements and pulses done
////////////////////////////////////////

`timescale 1ns/10ps

module vec_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic [vec_pkg::idx_w-1:0] elem_idx,
    output logic                     wr_en,
    output logic                     advance,
    output logic                     busy,
    output logic                     done
);

    import vec_pkg::*;

    ctrl_state_e state;

    localparam logic [idx_w-1:0] last_idx = idx_w'(n_elem - 1);

    // Start only counts while idle
    assign advance = (state == st_idle) && start;
    assign wr_en   = (state == st_compute);  // One slot per compute cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            elem_idx <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    done <= 1'b0;
                    if (start) begin
                        elem_idx <= '0;
                        busy     <= 1'b1;
                        state    <= st_compute;
                    end
                end
                st_compute: begin
                    elem_idx <= elem_idx + 1'b1;  // Wraps back to 0 after last
                    if (elem_idx == last_idx) begin
                        state <= st_complete;
                    end
                end
                st_complete: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // done is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    // An accepted start gives exactly eight writes, all in compute,
    // then done one cycle after the last write window closes
    a_write_window: assert property (
        @(posedge clk) disable iff (rst)
        advance |=> (wr_en && state == st_compute) [*8]
                    ##1 (!wr_en && state == st_complete)
                    ##1 (done && !busy)
    );

    // Writes stay inside the busy window
    a_wr_in_compute: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (busy && !done)
    );

endmodule

/* source/vec_pkg.sv */
////////////////////////////////////////
// Vector unit shared definitions
// Sizes, LFSR seed and the enum types
////////////////////////////////////////

package vec_pkg;

    // Element and vector sizes
    localparam int elem_w    = 8;   // One operand byte
    localparam int res_w     = 16;  // One element result
    localparam int n_elem    = 8;
    localparam int vec_w     = elem_w * n_elem;  // 64
    localparam int res_vec_w = res_w * n_elem;   // 128
    localparam int idx_w     = 3;

    // Coefficient generator
    localparam int lfsr_w = 64;
    localparam logic [lfsr_w-1:0] lfsr_seed = 64'h1234_5678_9ABC_DEF0;

    // Element functions, encoding matches the vector_op input
    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_mul   = 3'd2,
        op_mac   = 3'd3,  // Uses coefficient c
        op_logic = 3'd4,
        op_xor   = 3'd5,  // Uses coefficient c
        op_max   = 3'd6,  // Uses coefficient e
        op_sad   = 3'd7   // Uses coefficient d
    } vec_op_e;

    // Controller states
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_compute  = 2'd1,
        st_complete = 2'd2
    } ctrl_state_e;

endpackage

/* source/vector_unit.sv */
////////////////////////////////////////
// Vector unit top
// Controller, LFSR, ALU and result buffer
////////////////////////////////////////

`timescale 1ns/10ps

module vector_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [vec_pkg::vec_w-1:0]     vector_a,   // Held stable until done
    input  logic [vec_pkg::vec_w-1:0]     vector_b,
    input  vec_pkg::vec_op_e              vector_op,
    output logic [vec_pkg::res_vec_w-1:0] vector_result,
    output logic                         done,
    output logic                         busy
);

    import vec_pkg::*;

    logic [idx_w-1:0]  elem_idx;
    logic              wr_en;
    logic              advance;
    logic [lfsr_w-1:0] lfsr_state;
    logic [res_w-1:0]  elem_result;

    vec_ctrl ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .elem_idx (elem_idx),
        .wr_en    (wr_en),
        .advance  (advance),
        .busy     (busy),
        .done     (done)
    );

    // Fresh coefficients for every operation
    coef_lfsr lfsr_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .lfsr_state (lfsr_state)
    );

    elem_alu alu_i (
        .vector_a    (vector_a),
        .vector_b    (vector_b),
        .elem_idx    (elem_idx),
        .vector_op   (vector_op),
        .lfsr_state  (lfsr_state),
        .elem_result (elem_result)
    );

    result_buffer buf_i (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .elem_idx      (elem_idx),
        .elem_result   (elem_result),
        .vector_result (vector_result)
    );

endmodule

/* testbench/tb_vector_tasks.svh */
////////////////////////////////////////
// Vector unit model, checks and tests
////////////////////////////////////////

`ifndef TB_VECTOR_TASKS_SVH
`define TB_VECTOR_TASKS_SVH

// Shift left with taps 63, 31 and 15 feeding bit 0
function automatic logic [lfsr_w-1:0] lfsr_step(logic [lfsr_w-1:0] s);
    logic fb;
    fb = s[63] ^ s[31] ^ s[15];
    return {s[62:0], fb};
endfunction

function automatic logic [res_w-1:0] model_elem(vec_op_e op, logic [7:0] a, logic [7:0] b,
                                                logic [lfsr_w-1:0] coef);
    int ai;
    int bi;
    int ci;
    int di;
    int ei;
    int r;
    ai = a;
    bi = b;
    ci = coef[23:16];
    di = coef[15:8];
    ei = coef[7:0];
    case (op)
        op_add:   r = ai + bi;
        op_sub:   r = ai - bi;  // Negative values truncate to two's complement
        op_mul:   r = ai * bi;
        op_mac:   r = ai * bi + ci;
        op_logic: r = ((ai & bi) << 8) | (ai | bi);
        op_xor:   r = (ci << 8) | (ai ^ bi);
        op_max:   r = (ei << 8) | ((ai >= bi) ? ai : bi);
        op_sad:   r = ((ai >= bi) ? ai - bi : bi - ai) + di;
        default:  r = 0;
    endcase
    return r[15:0];
endfunction

function automatic logic [res_vec_w-1:0] model_vector(vec_op_e op, logic [vec_w-1:0] va,
                                                      logic [vec_w-1:0] vb,
                                                      logic [lfsr_w-1:0] coef);
    logic [res_vec_w-1:0] r;
    for (int i = 0; i < n_elem; i++) begin
        r[i*16 +: 16] = model_elem(op, va[i*8 +: 8], vb[i*8 +: 8], coef);
    end
    return r;
endfunction

task automatic compare_result(string name, logic [res_vec_w-1:0] expected,
                              logic [res_vec_w-1:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic compare_flag(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
    end
endtask

// One operation plus an optional extra start while the DUT is busy
task automatic issue_op(string name, vec_op_e op, logic [vec_w-1:0] va,
                        logic [vec_w-1:0] vb, bit poke_busy);
    logic [res_vec_w-1:0] expected;
    int                   cycles;
    bit                   seen;
    @(posedge clk);
    vector_a  <= va;
    vector_b  <= vb;
    vector_op <= op;
    start     <= 1'b1;
    lfsr_model = lfsr_step(lfsr_model);  // Only the accepted start advances
    expected   = model_vector(op, va, vb, lfsr_model);
    cycles     = 0;
    seen       = 1'b0;
    while (!seen && cycles < done_timeout) begin
        @(posedge clk);
        start <= (poke_busy && cycles == 3);
        @(negedge clk);
        cycles++;
        if (done) begin
            seen = 1'b1;
        end else begin
            compare_flag({name, " busy"}, 1'b1, busy);
        end
    end
    if (!seen) begin
        errors++;
        $display("ERROR %s: done never rose within %0d cycles", name, done_timeout);
        end_with_failure();
    end else begin
        checks++;
        if (cycles != done_latency) begin
            errors++;
            $display("MISMATCH %s latency: expected %0d, actual %0d",
                     name, done_latency, cycles);
        end
        compare_flag({name, " busy at done"}, 1'b0, busy);
        compare_result(name, expected, vector_result);
        @(negedge clk);
        compare_flag({name, " done pulse end"}, 1'b0, done);
        compare_flag({name, " busy after done"}, 1'b0, busy);
        compare_result({name, " after done"}, expected, vector_result);
    end
endtask

task automatic check_reset_state();
    @(negedge clk);
    compare_result("reset result", '0, vector_result);
    compare_flag("reset done", 1'b0, done);
    compare_flag("reset busy", 1'b0, busy);
endtask

task automatic run_fixed_vectors();
    vec_op_e op;
    for (int i = 0; i < 8; i++) begin
        op = vec_op_e'(i);
        issue_op($sformatf("fixed %s", op.name()), op,
                 64'hFF00_80FF_7F01_0010, 64'h00FF_FF80_807F_0010, 1'b0);
        issue_op($sformatf("fixed max %s", op.name()), op,
                 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
    end
endtask

task automatic run_random_vectors();
    vec_op_e op;
    for (int round = 0; round < 3; round++) begin
        for (int i = 0; i < 8; i++) begin
            op = vec_op_e'(i);
            issue_op($sformatf("random %0d %s", round, op.name()), op,
                     {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, 1'b0);
        end
    end
endtask

task automatic ignore_start_while_busy();
    issue_op("busy start mac", op_mac, {$random(seed), $random(seed)},
             {$random(seed), $random(seed)}, 1'b1);
    issue_op("busy start sad", op_sad, 64'h0102_0304_0506_0708,
             64'h0807_0605_0403_0201, 1'b1);
    // A wrongly accepted start would shift the coefficients seen here
    issue_op("after busy start", op_xor, 64'hA5A5_5A5A_0F0F_F0F0, 64'h0, 1'b0);
endtask

task automatic back_to_back_ops();
    logic [vec_w-1:0] va;
    logic [vec_w-1:0] vb;
    va = {$random(seed), $random(seed)};
    vb = {$random(seed), $random(seed)};
    for (int i = 0; i < 4; i++) begin
        issue_op($sformatf("back to back mac %0d", i), op_mac, va, vb, 1'b0);
        issue_op($sformatf("back to back max %0d", i), op_max, va, vb, 1'b0);
    end
endtask

task automatic hold_result_when_idle();
    logic [vec_w-1:0]     va;
    logic [vec_w-1:0]     vb;
    logic [res_vec_w-1:0] held;
    va = 64'hF0F0_3C3C_AAAA_0001;
    vb = 64'h0FF0_C33C_5555_FF01;
    issue_op("hold setup", op_logic, va, vb, 1'b0);
    held = model_vector(op_logic, va, vb, lfsr_model);
    for (int i = 0; i < 6; i++) begin
        @(posedge clk);
        vector_a  <= {$random(seed), $random(seed)};  // Inputs move but the result must hold
        vector_op <= vec_op_e'(i);
        @(negedge clk);
        compare_result($sformatf("hold idle %0d", i), held, vector_result);
        compare_flag($sformatf("hold busy %0d", i), 1'b0, busy);
    end
endtask

`endif

/* testbench/tb_vector_unit.sv */
////////////////////////////////////////
// Vector unit testbench
// Clock, reset, DUT and test sequence
////////////////////////////////////////

`timescale 1ns/10ps

module tb_vector_unit;

    import vec_pkg::*;

    localparam int done_latency = 10;  // Falling edges from accept to done
    localparam int done_timeout = 40;

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic [vec_w-1:0]     vector_a;
    logic [vec_w-1:0]     vector_b;
    vec_op_e              vector_op;
    logic [res_vec_w-1:0] vector_result;
    logic                 done;
    logic                 busy;

    integer            seed;
    int                errors;
    int                checks;
    logic [lfsr_w-1:0] lfsr_model;  // Tracks the DUT coefficient register

    vector_unit dut_i (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .vector_a      (vector_a),
        .vector_b      (vector_b),
        .vector_op     (vector_op),
        .vector_result (vector_result),
        .done          (done),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reports the counts and stops after a hang
    task automatic end_with_failure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    `include "tb_vector_tasks.svh"

    initial begin
        seed       = 32'h1fe2_1639;
        errors     = 0;
        checks     = 0;
        lfsr_model = lfsr_seed;
        rst        = 1'b1;
        start      = 1'b0;
        vector_a   = '0;
        vector_b   = '0;
        vector_op  = op_add;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        run_fixed_vectors();
        run_random_vectors();
        ignore_start_while_busy();
        back_to_back_ops();
        hold_result_when_idle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
